// File: source/be_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, queue sizing and encodings shared by the issue scheduler blocks.
// Modules pull these in with a wildcard import in their headers.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package be_pkg;

  // Datapath and address width
  localparam int xlen_lp = 32;

  // Issue queue depth
  localparam int queue_els_lp = 8;
  localparam int queue_idx_width_lp = $clog2(queue_els_lp);

  // Extra wrap bit tells full from empty
  localparam int queue_ptr_width_lp = queue_idx_width_lp + 1;

  localparam int reg_addr_width_lp = 5;

  // SYSTEM funct12 patterns accepted by the decoder
  localparam logic [11:0] funct12_ecall_lp  = 12'h000;
  localparam logic [11:0] funct12_ebreak_lp = 12'h001;
  localparam logic [11:0] funct12_wfi_lp    = 12'h105;
  localparam logic [11:0] funct12_mret_lp   = 12'h302;

  // RV32I major opcodes
  typedef enum logic [6:0]
  {
    e_op_lui    = 7'b0110111
    , e_op_auipc  = 7'b0010111
    , e_op_jal    = 7'b1101111
    , e_op_jalr   = 7'b1100111
    , e_op_branch = 7'b1100011
    , e_op_load   = 7'b0000011
    , e_op_store  = 7'b0100011
    , e_op_op_imm = 7'b0010011
    , e_op_op     = 7'b0110011
    , e_op_system = 7'b1110011
  } be_opcode_e;

  // Functional unit class, none must stay the zero code
  typedef enum logic [2:0]
  {
    e_fu_none     = 3'd0
    , e_fu_alu    = 3'd1
    , e_fu_branch = 3'd2
    , e_fu_jump   = 3'd3
    , e_fu_load   = 3'd4
    , e_fu_store  = 3'd5
    , e_fu_system = 3'd6
  } be_fu_e;

endpackage

// File: source/be_issue_queue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular queue of fetched instructions between fetch and dispatch.
// Reads move a speculative pointer; commits free entries; roll replays
// every read but uncommitted entry and clear drops all of them.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module be_issue_queue
  import be_pkg::*;
  (input                              clk_i
   , input                            rst_n_i

   , input                            fetch_v_i
   , input [xlen_lp-1:0]              fetch_pc_i
   , input [xlen_lp-1:0]              fetch_instr_i
   , input                            fetch_fault_i
   , output logic                     fetch_ready_o

   , input                            read_v_i
   , input                            commit_v_i
   , input                            roll_v_i
   , input                            clear_i

   , output logic                     issue_v_o
   , output logic [xlen_lp-1:0]       issue_pc_o
   , output logic [xlen_lp-1:0]       issue_instr_o
   , output logic                     issue_fault_o
   );

  logic [xlen_lp-1:0] pc_mem    [queue_els_lp];
  logic [xlen_lp-1:0] instr_mem [queue_els_lp];
  logic               fault_mem [queue_els_lp];

  logic [queue_ptr_width_lp-1:0] wptr_r, rptr_r, cptr_r;
  logic [queue_ptr_width_lp-1:0] wptr_inc, rptr_inc, cptr_inc;

  logic [queue_idx_width_lp-1:0] widx, ridx;
  logic                          full;
  logic                          fetch_w;

  assign widx = wptr_r[queue_idx_width_lp-1:0];
  assign ridx = rptr_r[queue_idx_width_lp-1:0];

  assign wptr_inc = wptr_r + 1'b1;
  assign rptr_inc = rptr_r + 1'b1;
  assign cptr_inc = cptr_r + 1'b1;

  // Full counts from commit, read entries still hold their slot
  assign full = (wptr_r[queue_ptr_width_lp-1] != cptr_r[queue_ptr_width_lp-1])
                && (widx == cptr_r[queue_idx_width_lp-1:0]);

  assign fetch_ready_o = ~full;
  assign fetch_w       = fetch_v_i & fetch_ready_o;

  always_ff @(posedge clk_i)
    begin
      if (fetch_w)
        begin
          pc_mem[widx]    <= fetch_pc_i;
          instr_mem[widx] <= fetch_instr_i;
          fault_mem[widx] <= fetch_fault_i;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          wptr_r <= '0;
          rptr_r <= '0;
          cptr_r <= '0;
        end
      else
        begin
          if (fetch_w)
            begin
              wptr_r <= wptr_inc;
            end

          if (clear_i)
            begin
              rptr_r <= wptr_r;
              cptr_r <= wptr_r;
            end
          else if (roll_v_i)
            begin
              // Replay from the oldest uncommitted entry
              rptr_r <= cptr_r;
            end
          else
            begin
              if (read_v_i)
                begin
                  rptr_r <= rptr_inc;
                end
              if (commit_v_i)
                begin
                  cptr_r <= cptr_inc;
                end
            end
        end
    end

  assign issue_v_o     = (rptr_r != wptr_r);
  assign issue_pc_o    = pc_mem[ridx];
  assign issue_instr_o = instr_mem[ridx];
  assign issue_fault_o = fault_mem[ridx];

endmodule

// File: source/be_regfile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer register file with two asynchronous read ports and one write
// port. Writes land on the clock edge and x0 always reads as zero.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module be_regfile
  import be_pkg::*;
  (input                                   clk_i
   , input                                 rst_n_i

   , input                                 wr_v_i
   , input [reg_addr_width_lp-1:0]         wr_addr_i
   , input [xlen_lp-1:0]                   wr_data_i

   , input [reg_addr_width_lp-1:0]         rs1_addr_i
   , input [reg_addr_width_lp-1:0]         rs2_addr_i
   , output logic [xlen_lp-1:0]            rs1_data_o
   , output logic [xlen_lp-1:0]            rs2_data_o
   );

  logic [xlen_lp-1:0] regs_r [2**reg_addr_width_lp];

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          for (int i = 0; i < 2**reg_addr_width_lp; i++)
            begin
              regs_r[i] <= '0;
            end
        end
      else if (wr_v_i && (wr_addr_i != '0))
        begin
          // x0 stays zero since it is never written
          regs_r[wr_addr_i] <= wr_data_i;
        end
    end

  // No bypass, a write shows up the cycle after its edge
  assign rs1_data_o = regs_r[rs1_addr_i];
  assign rs2_data_o = regs_r[rs2_addr_i];

endmodule

// File: source/be_instr_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational RV32I decode of the queue head: unit class, immediate
// and the exception and special flags seen by the dispatch former.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module be_instr_decoder
  import be_pkg::*;
  (input [xlen_lp-1:0]           instr_i

   , output be_fu_e              fu_o
   , output logic [xlen_lp-1:0]  imm_o

   , output logic                illegal_o
   , output logic                ecall_o
   , output logic                ebreak_o
   , output logic                mret_o
   , output logic                wfi_o
   );

  be_opcode_e opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic        sys_regs_zero;

  logic [xlen_lp-1:0] imm_i_type, imm_s_type, imm_b_type, imm_u_type, imm_j_type;

  assign opcode  = be_opcode_e'(instr_i[6:0]);
  assign funct3  = instr_i[14:12];
  assign funct12 = instr_i[31:20];

  // rd and rs1 are zero in every accepted SYSTEM form
  assign sys_regs_zero = (instr_i[11:7] == '0) && (instr_i[19:15] == '0) && (funct3 == '0);

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb
    begin
      fu_o      = e_fu_none;
      imm_o     = '0;
      illegal_o = 1'b0;
      ecall_o   = 1'b0;
      ebreak_o  = 1'b0;
      mret_o    = 1'b0;
      wfi_o     = 1'b0;

      case (opcode)
        e_op_lui, e_op_auipc:
          begin
            fu_o  = e_fu_alu;
            imm_o = imm_u_type;
          end
        e_op_op_imm:
          begin
            fu_o  = e_fu_alu;
            imm_o = imm_i_type;
          end
        e_op_op:     fu_o = e_fu_alu;
        e_op_branch:
          begin
            fu_o  = e_fu_branch;
            imm_o = imm_b_type;
          end
        e_op_jal:
          begin
            fu_o  = e_fu_jump;
            imm_o = imm_j_type;
          end
        e_op_jalr:
          begin
            fu_o  = e_fu_jump;
            imm_o = imm_i_type;
          end
        e_op_load:
          begin
            fu_o  = e_fu_load;
            imm_o = imm_i_type;
          end
        e_op_store:
          begin
            fu_o  = e_fu_store;
            imm_o = imm_s_type;
          end
        e_op_system:
          begin
            fu_o     = e_fu_system;
            imm_o    = imm_i_type;
            ecall_o  = sys_regs_zero && (funct12 == funct12_ecall_lp);
            ebreak_o = sys_regs_zero && (funct12 == funct12_ebreak_lp);
            mret_o   = sys_regs_zero && (funct12 == funct12_mret_lp);
            wfi_o    = sys_regs_zero && (funct12 == funct12_wfi_lp);
            // CSR accesses and other forms are not supported
            illegal_o = ~(ecall_o | ebreak_o | mret_o | wfi_o);
          end
        default:     illegal_o = 1'b1;
      endcase
    end

endmodule

// File: source/be_dispatch_former.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Builds the dispatch packet from the queue head, its operands and its
// decode. An injected interrupt takes the slot ahead of a queue read.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module be_dispatch_former
  import be_pkg::*;
  (input                          read_v_i
   , input                        interrupt_v_i
   , input                        poison_i
   , input [xlen_lp-1:0]          expected_npc_i

   , input [xlen_lp-1:0]          issue_pc_i
   , input [xlen_lp-1:0]          issue_instr_i
   , input                        issue_fault_i

   , input [xlen_lp-1:0]          rs1_data_i
   , input [xlen_lp-1:0]          rs2_data_i
   , input be_fu_e                fu_i
   , input [xlen_lp-1:0]          imm_i
   , input                        illegal_i
   , input                        ecall_i
   , input                        ebreak_i
   , input                        mret_i
   , input                        wfi_i

   , output logic                 dispatch_v_o
   , output logic [xlen_lp-1:0]   dispatch_pc_o
   , output logic                 dispatch_instr_v_o
   , output logic [xlen_lp-1:0]   dispatch_rs1_o
   , output logic [xlen_lp-1:0]   dispatch_rs2_o
   , output logic [xlen_lp-1:0]   dispatch_imm_o
   , output be_fu_e               dispatch_fu_o
   , output logic                 exc_fetch_fault_o
   , output logic                 exc_illegal_o
   , output logic                 exc_ecall_o
   , output logic                 exc_ebreak_o
   , output logic                 exc_interrupt_o
   , output logic                 special_mret_o
   , output logic                 special_wfi_o
   );

  logic queue_read, fe_instr, fe_exc, no_operands;

  // Interrupt wins, so the head is not consumed as an instruction
  assign queue_read  = read_v_i & ~interrupt_v_i;
  assign fe_instr    = queue_read & ~issue_fault_i;
  assign fe_exc      = queue_read &  issue_fault_i;
  assign no_operands = interrupt_v_i | fe_exc;

  assign dispatch_v_o       = (read_v_i & ~poison_i) | interrupt_v_i;
  assign dispatch_pc_o      = expected_npc_i;
  assign dispatch_instr_v_o = fe_instr;

  // Faulting pc goes out on rs1
  assign dispatch_rs1_o = interrupt_v_i ? '0 : fe_exc ? issue_pc_i : rs1_data_i;
  assign dispatch_rs2_o = no_operands ? '0 : rs2_data_i;

  // Illegal instruction bits travel as the trap value
  assign dispatch_imm_o = no_operands ? '0 : illegal_i ? issue_instr_i : imm_i;
  assign dispatch_fu_o  = (no_operands | illegal_i) ? e_fu_none : fu_i;

  assign exc_fetch_fault_o = fe_exc;
  assign exc_interrupt_o   = interrupt_v_i;
  assign exc_illegal_o     = fe_instr & illegal_i;
  assign exc_ecall_o       = fe_instr & ecall_i;
  assign exc_ebreak_o      = fe_instr & ebreak_i;
  assign special_mret_o    = fe_instr & mret_i;
  assign special_wfi_o     = fe_instr & wfi_i;

endmodule

// File: source/be_scheduler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue scheduler top. Register file and decoder work side by side on
// the queue head and the dispatch former merges their results.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module be_scheduler
  import be_pkg::*;
  (input                              clk_i
   , input                            rst_n_i

   , input                            fetch_v_i
   , input [xlen_lp-1:0]              fetch_pc_i
   , input [xlen_lp-1:0]              fetch_instr_i
   , input                            fetch_fault_i
   , output logic                     fetch_ready_o

   , output logic                     issue_v_o
   , input                            read_v_i
   , input                            commit_v_i
   , input                            roll_v_i
   , input                            clear_i

   , input                            wb_v_i
   , input [reg_addr_width_lp-1:0]    wb_addr_i
   , input [xlen_lp-1:0]              wb_data_i

   , input                            interrupt_v_i
   , input                            poison_i
   , input [xlen_lp-1:0]              expected_npc_i

   , output logic                     dispatch_v_o
   , output logic [xlen_lp-1:0]       dispatch_pc_o
   , output logic                     dispatch_instr_v_o
   , output logic [xlen_lp-1:0]       dispatch_rs1_o
   , output logic [xlen_lp-1:0]       dispatch_rs2_o
   , output logic [xlen_lp-1:0]       dispatch_imm_o
   , output be_fu_e                   dispatch_fu_o
   , output logic                     exc_fetch_fault_o
   , output logic                     exc_illegal_o
   , output logic                     exc_ecall_o
   , output logic                     exc_ebreak_o
   , output logic                     exc_interrupt_o
   , output logic                     special_mret_o
   , output logic                     special_wfi_o
   );

  logic [xlen_lp-1:0] issue_pc_lo, issue_instr_lo;
  logic               issue_fault_lo;
  logic [xlen_lp-1:0] irf_rs1_lo, irf_rs2_lo;
  be_fu_e             fu_lo;
  logic [xlen_lp-1:0] imm_lo;
  logic               illegal_lo, ecall_lo, ebreak_lo, mret_lo, wfi_lo;

  be_issue_queue issue_queue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.fetch_v_i(fetch_v_i)
     ,.fetch_pc_i(fetch_pc_i)
     ,.fetch_instr_i(fetch_instr_i)
     ,.fetch_fault_i(fetch_fault_i)
     ,.fetch_ready_o(fetch_ready_o)
     ,.read_v_i(read_v_i)
     ,.commit_v_i(commit_v_i)
     ,.roll_v_i(roll_v_i)
     ,.clear_i(clear_i)
     ,.issue_v_o(issue_v_o)
     ,.issue_pc_o(issue_pc_lo)
     ,.issue_instr_o(issue_instr_lo)
     ,.issue_fault_o(issue_fault_lo)
     );

  be_regfile int_regfile
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.wr_v_i(wb_v_i)
     ,.wr_addr_i(wb_addr_i)
     ,.wr_data_i(wb_data_i)
     ,.rs1_addr_i(issue_instr_lo[19:15])
     ,.rs2_addr_i(issue_instr_lo[24:20])
     ,.rs1_data_o(irf_rs1_lo)
     ,.rs2_data_o(irf_rs2_lo)
     );

  be_instr_decoder instr_decoder
    (.instr_i(issue_instr_lo)
     ,.fu_o(fu_lo)
     ,.imm_o(imm_lo)
     ,.illegal_o(illegal_lo)
     ,.ecall_o(ecall_lo)
     ,.ebreak_o(ebreak_lo)
     ,.mret_o(mret_lo)
     ,.wfi_o(wfi_lo)
     );

  be_dispatch_former dispatch_former
    (.read_v_i(read_v_i)
     ,.interrupt_v_i(interrupt_v_i)
     ,.poison_i(poison_i)
     ,.expected_npc_i(expected_npc_i)
     ,.issue_pc_i(issue_pc_lo)
     ,.issue_instr_i(issue_instr_lo)
     ,.issue_fault_i(issue_fault_lo)
     ,.rs1_data_i(irf_rs1_lo)
     ,.rs2_data_i(irf_rs2_lo)
     ,.fu_i(fu_lo)
     ,.imm_i(imm_lo)
     ,.illegal_i(illegal_lo)
     ,.ecall_i(ecall_lo)
     ,.ebreak_i(ebreak_lo)
     ,.mret_i(mret_lo)
     ,.wfi_i(wfi_lo)
     ,.dispatch_v_o(dispatch_v_o)
     ,.dispatch_pc_o(dispatch_pc_o)
     ,.dispatch_instr_v_o(dispatch_instr_v_o)
     ,.dispatch_rs1_o(dispatch_rs1_o)
     ,.dispatch_rs2_o(dispatch_rs2_o)
     ,.dispatch_imm_o(dispatch_imm_o)
     ,.dispatch_fu_o(dispatch_fu_o)
     ,.exc_fetch_fault_o(exc_fetch_fault_o)
     ,.exc_illegal_o(exc_illegal_o)
     ,.exc_ecall_o(exc_ecall_o)
     ,.exc_ebreak_o(exc_ebreak_o)
     ,.exc_interrupt_o(exc_interrupt_o)
     ,.special_mret_o(special_mret_o)
     ,.special_wfi_o(special_wfi_o)
     );

endmodule

// File: verif/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free running testbench clock with a period of 100 time units.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen
  (output logic clk_o
   );

  initial
    begin
      clk_o = 1'b0;
    end

  always #50 clk_o = ~clk_o;

endmodule

// File: verif/tb_be_scheduler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the issue scheduler. A reference queue and
// register model predict each cycle and concurrent assertions compare.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_be_scheduler
  import be_pkg::*;
  ();

  localparam logic [31:0] seed_lp        = 32'h56b8;
  localparam int          timeout_lp     = 200;
  localparam logic [31:0] ecall_word_lp  = 32'h00000073;
  localparam logic [31:0] ebreak_word_lp = 32'h00100073;
  localparam logic [31:0] mret_word_lp   = 32'h30200073;
  localparam logic [31:0] wfi_word_lp    = 32'h10500073;

  logic clk, rst_n;
  logic fetch_v, fetch_fault, fetch_ready;
  logic [xlen_lp-1:0] fetch_pc, fetch_instr;
  logic issue_v, read_v, commit_v, roll_v, clear;
  logic wb_v;
  logic [reg_addr_width_lp-1:0] wb_addr;
  logic [xlen_lp-1:0] wb_data, expected_npc;
  logic interrupt_v, poison;
  logic dispatch_v, dispatch_instr_v;
  logic [xlen_lp-1:0] dispatch_pc, dispatch_rs1, dispatch_rs2, dispatch_imm;
  be_fu_e dispatch_fu;
  logic exc_fetch_fault, exc_illegal, exc_ecall, exc_ebreak, exc_interrupt;
  logic special_mret, special_wfi;

  // Reference model state, pointers never wrap
  logic [xlen_lp-1:0] m_pc    [queue_els_lp];
  logic [xlen_lp-1:0] m_instr [queue_els_lp];
  logic               m_fault [queue_els_lp];
  logic [xlen_lp-1:0] m_regs  [32];
  int m_wptr, m_rptr, m_cptr;

  logic [xlen_lp-1:0] h_pc, h_instr, exp_rs1, exp_rs2, exp_imm;
  logic h_fault, h_legal, exp_ready, exp_issue_v, rd_exc, rd_instr, no_ops, imm_checked;
  logic [7:0] exp_flags;
  be_fu_e exp_fu;

  logic [31:0] lcg_state;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  tb_clock_gen clock_gen (.clk_o(clk));

  be_scheduler uut
    (.clk_i(clk), .rst_n_i(rst_n)
     ,.fetch_v_i(fetch_v), .fetch_pc_i(fetch_pc), .fetch_instr_i(fetch_instr)
     ,.fetch_fault_i(fetch_fault), .fetch_ready_o(fetch_ready)
     ,.issue_v_o(issue_v), .read_v_i(read_v), .commit_v_i(commit_v)
     ,.roll_v_i(roll_v), .clear_i(clear)
     ,.wb_v_i(wb_v), .wb_addr_i(wb_addr), .wb_data_i(wb_data)
     ,.interrupt_v_i(interrupt_v), .poison_i(poison), .expected_npc_i(expected_npc)
     ,.dispatch_v_o(dispatch_v), .dispatch_pc_o(dispatch_pc)
     ,.dispatch_instr_v_o(dispatch_instr_v), .dispatch_rs1_o(dispatch_rs1)
     ,.dispatch_rs2_o(dispatch_rs2), .dispatch_imm_o(dispatch_imm), .dispatch_fu_o(dispatch_fu)
     ,.exc_fetch_fault_o(exc_fetch_fault), .exc_illegal_o(exc_illegal)
     ,.exc_ecall_o(exc_ecall), .exc_ebreak_o(exc_ebreak), .exc_interrupt_o(exc_interrupt)
     ,.special_mret_o(special_mret), .special_wfi_o(special_wfi)
     );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic be_fu_e unit_of(input logic [31:0] ins);
    case (ins[6:0])
      e_op_lui, e_op_auipc, e_op_op_imm, e_op_op: return e_fu_alu;
      e_op_branch:                                return e_fu_branch;
      e_op_jal, e_op_jalr:                        return e_fu_jump;
      e_op_load:                                  return e_fu_load;
      e_op_store:                                 return e_fu_store;
      e_op_system:                                return e_fu_system;
      default:                                    return e_fu_none;
    endcase
  endfunction

  // Immediate formats by RV32I instruction type
  function automatic logic [31:0] imm_of(input logic [31:0] ins);
    case (ins[6:0])
      e_op_lui, e_op_auipc: return {ins[31:12], 12'h000};
      e_op_jal:    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      e_op_branch: return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      e_op_store:  return {{21{ins[31]}}, ins[30:25], ins[11:7]};
      e_op_op:     return '0;
      default:     return {{21{ins[31]}}, ins[30:20]};
    endcase
  endfunction

  function automatic logic is_legal(input logic [31:0] ins);
    if (unit_of(ins) == e_fu_none)
      return 1'b0;
    if (ins[6:0] == e_op_system)
      return ins inside {ecall_word_lp, ebreak_word_lp, mret_word_lp, wfi_word_lp};
    return 1'b1;
  endfunction

  always_comb
    begin
      h_pc        = m_pc[m_rptr % queue_els_lp];
      h_instr     = m_instr[m_rptr % queue_els_lp];
      h_fault     = m_fault[m_rptr % queue_els_lp];
      h_legal     = is_legal(h_instr);
      exp_issue_v = (m_rptr != m_wptr);
      exp_ready   = (m_wptr - m_cptr) < queue_els_lp;
      rd_exc      = read_v & ~interrupt_v & h_fault;
      rd_instr    = read_v & ~interrupt_v & ~h_fault;
      no_ops      = interrupt_v | rd_exc;
      exp_rs1     = interrupt_v ? '0 : rd_exc ? h_pc : m_regs[h_instr[19:15]];
      exp_rs2     = no_ops ? '0 : m_regs[h_instr[24:20]];
      exp_imm     = no_ops ? '0 : imm_of(h_instr);
      imm_checked = no_ops | h_legal;
      exp_fu      = (no_ops || !h_legal) ? e_fu_none : unit_of(h_instr);
      exp_flags   = {rd_instr, rd_exc, interrupt_v, rd_instr & ~h_legal,
                     rd_instr & (h_instr == ecall_word_lp), rd_instr & (h_instr == ebreak_word_lp),
                     rd_instr & (h_instr == mret_word_lp), rd_instr & (h_instr == wfi_word_lp)};
    end

  always @(posedge clk)
    begin
      if (!rst_n)
        begin
          m_wptr <= 0;
          m_rptr <= 0;
          m_cptr <= 0;
          for (int i = 0; i < 32; i++)
            m_regs[i] <= '0;
        end
      else
        begin
          if (fetch_v && exp_ready)
            begin
              m_pc[m_wptr % queue_els_lp]    <= fetch_pc;
              m_instr[m_wptr % queue_els_lp] <= fetch_instr;
              m_fault[m_wptr % queue_els_lp] <= fetch_fault;
              m_wptr <= m_wptr + 1;
            end
          if (clear)
            begin
              m_rptr <= m_wptr;
              m_cptr <= m_wptr;
            end
          else if (roll_v)
            m_rptr <= m_cptr;
          else
            begin
              if (read_v)
                m_rptr <= m_rptr + 1;
              if (commit_v)
                m_cptr <= m_cptr + 1;
            end
          if (wb_v && wb_addr != '0)
            m_regs[wb_addr] <= wb_data;
        end
    end

  task automatic flag_mismatch(input string what);
    $display("Error at time %0t: %s does not match the model", $time, what);
    errors++;
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) issue_v == exp_issue_v)
    else flag_mismatch("issue_v_o");
  assert property (@(posedge clk) disable iff (!rst_n) fetch_ready == exp_ready)
    else flag_mismatch("fetch_ready_o");
  assert property (@(posedge clk) disable iff (!rst_n)
                   dispatch_v == ((read_v & ~poison) | interrupt_v))
    else flag_mismatch("dispatch_v_o");
  assert property (@(posedge clk) disable iff (!rst_n) dispatch_v |-> dispatch_pc == expected_npc)
    else flag_mismatch("dispatch_pc_o");
  assert property (@(posedge clk) disable iff (!rst_n)
                   (dispatch_v || issue_v) |-> dispatch_rs1 == exp_rs1)
    else flag_mismatch("dispatch_rs1_o");
  assert property (@(posedge clk) disable iff (!rst_n)
                   (dispatch_v || issue_v) |-> dispatch_rs2 == exp_rs2)
    else flag_mismatch("dispatch_rs2_o");
  assert property (@(posedge clk) disable iff (!rst_n)
                   ((dispatch_v || issue_v) && imm_checked) |-> dispatch_imm == exp_imm)
    else flag_mismatch("dispatch_imm_o");
  assert property (@(posedge clk) disable iff (!rst_n)
                   (dispatch_v || issue_v) |-> dispatch_fu == exp_fu)
    else flag_mismatch("dispatch_fu_o");
  assert property (@(posedge clk) disable iff (!rst_n)
                   {dispatch_instr_v, exc_fetch_fault, exc_interrupt, exc_illegal, exc_ecall,
                    exc_ebreak, special_mret, special_wfi} == exp_flags)
    else flag_mismatch("exception flags");

  task automatic idle_inputs();
    fetch_v     = 1'b0;
    fetch_fault = 1'b0;
    read_v      = 1'b0;
    commit_v    = 1'b0;
    roll_v      = 1'b0;
    clear       = 1'b0;
    wb_v        = 1'b0;
    interrupt_v = 1'b0;
    poison      = 1'b0;
  endtask

  // Hold the strobes for one edge, then release them
  task automatic next_cycle();
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic wait_fetch_ready(output bit ok);
    int n;
    n = 0;
    while (!fetch_ready && n < timeout_lp)
      begin
        @(negedge clk);
        n++;
      end
    ok = fetch_ready;
    if (!ok)
      begin
        $display("Timed out at %0t waiting for the queue to accept a fetch", $time);
        errors++;
      end
  endtask

  task automatic wait_issue_valid(output bit ok);
    int n;
    n = 0;
    while (!issue_v && n < timeout_lp)
      begin
        @(negedge clk);
        n++;
      end
    ok = issue_v;
    if (!ok)
      begin
        $display("Timed out at %0t waiting for an entry to issue", $time);
        errors++;
      end
  endtask

  task automatic push_fetch(input logic [31:0] pc, input logic [31:0] instr, input logic fault);
    bit ok;
    wait_fetch_ready(ok);
    if (ok)
      begin
        fetch_v     = 1'b1;
        fetch_pc    = pc;
        fetch_instr = instr;
        fetch_fault = fault;
        next_cycle();
      end
  endtask

  task automatic read_head(input logic intr, input logic poisoned);
    bit ok;
    wait_issue_valid(ok);
    if (ok)
      begin
        read_v       = 1'b1;
        interrupt_v  = intr;
        poison       = poisoned;
        expected_npc = next_random();
        next_cycle();
      end
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_v    = 1'b1;
    wb_addr = addr;
    wb_data = data;
    next_cycle();
  endtask

  task automatic commit_entries(input int count);
    repeat (count)
      begin
        commit_v = 1'b1;
        next_cycle();
      end
  endtask

  task automatic order_operands_test();
    logic [31:0] ins;
    // x0 gets a write too, which must be dropped
    for (int r = 0; r < 32; r++)
      write_reg(r[4:0], next_random());
    for (int b = 0; b < 3; b++)
      begin
        for (int k = 0; k < 4; k++)
          begin
            ins = next_random();
            if (k == 0)
              ins[24:15] = '0;
            if (k[0])
              begin
                ins[6:0]   = e_op_op;
                ins[31:25] = ins[30] ? 7'h20 : 7'h00;
              end
            else
              ins[6:0] = e_op_op_imm;
            push_fetch(next_random() & ~32'h3, ins, 1'b0);
          end
        repeat (4) read_head(1'b0, 1'b0);
        commit_entries(4);
      end
  endtask

  task automatic exception_test();
    push_fetch(32'h0000_1000, next_random(), 1'b1);
    push_fetch(32'h0000_1004, ecall_word_lp, 1'b0);
    push_fetch(32'h0000_1008, ebreak_word_lp, 1'b0);
    push_fetch(32'h0000_100c, mret_word_lp, 1'b0);
    push_fetch(32'h0000_1010, wfi_word_lp, 1'b0);
    // Custom opcode and a CSR write are both outside the decoded set
    push_fetch(32'h0000_1014, 32'h0000_000b, 1'b0);
    push_fetch(32'h0000_1018, 32'h3000_1073, 1'b0);
    repeat (7) read_head(1'b0, 1'b0);
    commit_entries(7);
  endtask

  task automatic inject_poison_test();
    logic [31:0] word;
    for (int k = 0; k < 3; k++)
      begin
        word = next_random();
        push_fetch(32'h0000_2000 + 4 * k, {word[31:7], 7'b0010011}, 1'b0);
      end
    read_head(1'b1, 1'b0);
    read_head(1'b0, 1'b1);
    read_head(1'b0, 1'b0);
    commit_entries(3);
    // Interrupt with nothing queued
    interrupt_v  = 1'b1;
    expected_npc = next_random();
    next_cycle();
  endtask

  task automatic backpressure_test();
    logic [31:0] word;
    clear = 1'b1;
    next_cycle();
    for (int k = 0; k < queue_els_lp; k++)
      begin
        word = next_random();
        push_fetch(32'h0000_3000 + 4 * k, {word[31:7], 7'b0110011}, 1'b0);
      end
    read_head(1'b0, 1'b0);
    commit_entries(1);
    next_cycle();
  endtask

  task automatic replay_clear_test();
    clear = 1'b1;
    next_cycle();
    // Each entry carries its own immediate so the replayed head is visible
    for (int k = 0; k < 4; k++)
      push_fetch(32'h0000_4000 + 4 * k, {12'(k + 1), 20'h00013}, 1'b0);
    repeat (3) read_head(1'b0, 1'b0);
    commit_entries(1);
    roll_v = 1'b1;
    next_cycle();
    read_head(1'b0, 1'b0);
    clear = 1'b1;
    next_cycle();
    next_cycle();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("%s: passed", name);
    else
      begin
        tests_failed++;
        $display("%s: failed with %0d errors", name, errors - errors_before);
      end
  endtask

  initial
    begin
      int start;
      lcg_state    = seed_lp;
      rst_n        = 1'b0;
      fetch_pc     = '0;
      fetch_instr  = '0;
      wb_addr      = '0;
      wb_data      = '0;
      expected_npc = '0;
      idle_inputs();
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      start = errors;
      order_operands_test();
      finish_test("order and operands", start);
      start = errors;
      exception_test();
      finish_test("exceptions", start);
      start = errors;
      inject_poison_test();
      finish_test("injection and poison", start);
      start = errors;
      backpressure_test();
      finish_test("back-pressure", start);
      start = errors;
      replay_clear_test();
      finish_test("replay and clear", start);

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
        $display("ALL TESTS PASSED");
      else
        $display("SOME TESTS FAILED");
      $finish;
    end

endmodule

// File: list.f
source/be_pkg.sv
source/be_issue_queue.sv
source/be_regfile.sv
source/be_instr_decoder.sv
source/be_dispatch_former.sv
source/be_scheduler.sv
verif/tb_clock_gen.sv
verif/tb_be_scheduler.sv

// File: Makefile
# Verilator build and run for the issue scheduler testbench

TOP             ?= tb_be_scheduler
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
